// File: Bender.yml
package:
  name: ifu_aligner

sources:
  - hw/fetch_pkg.sv
  - hw/instr_pkg.sv
  - hw/fetch_queue.sv
  - hw/fetch_slot_ctl.sv
  - hw/instr_align.sv
  - hw/ifu_aligner_top.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/tb_aligner.sv

// File: dv/tb_vectors.svh
//********************
// stimulus table rows, directed expected instructions and the lcg
//********************
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

   localparam logic [1:0]  OP_FETCH = 2'd0;
   localparam logic [1:0]  OP_FLUSH = 2'd1;
   localparam logic [1:0]  OP_ERROR = 2'd2;   // async error pulse followed by idle cycles
   localparam logic [1:0]  OP_DRAIN = 2'd3;   // run until every halfword is taken
   localparam int          N_RANDOM = 48;
   localparam logic [31:0] LCG_SEED = 32'heab0_b9a6;

   typedef struct packed {
      logic [1:0]  op;
      logic [31:0] addr;   // byte address of the first valid halfword
      logic [31:0] data;
      half_flags_t hval;
      half_flags_t icaf;
      half_flags_t dbecc;
   } fetch_row_t;

   fetch_row_t  tbl[$];
   logic [63:0] dir_exp[$];   // {instruction, byte address} of the first takes
   logic [31:0] lcg_state = LCG_SEED;

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic fetch_row_t make_row(logic [1:0] op, logic [31:0] addr,
                                           logic [31:0] data, half_flags_t hval,
                                           half_flags_t icaf, half_flags_t dbecc);
      fetch_row_t r;
      r.op    = op;
      r.addr  = addr;
      r.data  = data;
      r.hval  = hval;
      r.icaf  = icaf;
      r.dbecc = dbecc;
      return r;
   endfunction

   task automatic load_table();
      logic [31:0] r;
      logic [31:0] w;
      logic [31:0] addr;
      // mixed lengths, straddles, skipped lower half, faults
      tbl.push_back(make_row(OP_FETCH, 32'h100, 32'h4501_0001, 2'b11, 2'b00, 2'b00));
      tbl.push_back(make_row(OP_FETCH, 32'h104, 32'h0010_0513, 2'b11, 2'b01, 2'b00));
      tbl.push_back(make_row(OP_FETCH, 32'h108, 32'h0293_8082, 2'b11, 2'b00, 2'b00));
      tbl.push_back(make_row(OP_FETCH, 32'h10c, 32'h4585_0050, 2'b11, 2'b00, 2'b00));
      tbl.push_back(make_row(OP_FETCH, 32'h112, 32'h0000_1137, 2'b10, 2'b00, 2'b00));
      tbl.push_back(make_row(OP_FETCH, 32'h114, 32'h8082_0000, 2'b11, 2'b01, 2'b00));
      tbl.push_back(make_row(OP_FETCH, 32'h118, 32'h0001_0001, 2'b11, 2'b00, 2'b10));
      tbl.push_back(make_row(OP_DRAIN, '0, '0, '0, '0, '0));
      dir_exp.push_back({32'h0000_0001, 32'h100});
      dir_exp.push_back({32'h0000_4501, 32'h102});
      dir_exp.push_back({32'h0010_0513, 32'h104});
      dir_exp.push_back({32'h0000_8082, 32'h108});
      dir_exp.push_back({32'h0050_0293, 32'h10a});   // straddles 0x108/0x10c
      dir_exp.push_back({32'h0000_4585, 32'h10e});
      dir_exp.push_back({32'h0000_1137, 32'h112});
      dir_exp.push_back({32'h0000_8082, 32'h116});
      dir_exp.push_back({32'h0000_0001, 32'h118});
      dir_exp.push_back({32'h0000_0001, 32'h11a});
      // flush in the cycle that takes a lone 2-byte halfword
      tbl.push_back(make_row(OP_FETCH, 32'h182, 32'h0000_0001, 2'b10, 2'b00, 2'b00));
      tbl.push_back(make_row(OP_FLUSH, '0, '0, '0, '0, '0));
      // error stall, flush, restart at a new pc
      tbl.push_back(make_row(OP_FETCH, 32'h200, 32'h0001_4501, 2'b11, 2'b00, 2'b00));
      tbl.push_back(make_row(OP_FETCH, 32'h204, 32'h0010_0513, 2'b11, 2'b00, 2'b00));
      tbl.push_back(make_row(OP_ERROR, '0, '0, '0, '0, '0));
      tbl.push_back(make_row(OP_FLUSH, '0, '0, '0, '0, '0));
      tbl.push_back(make_row(OP_FETCH, 32'h300, 32'h0293_0001, 2'b11, 2'b00, 2'b00));
      tbl.push_back(make_row(OP_FETCH, 32'h304, 32'h4501_0050, 2'b11, 2'b00, 2'b01));
      // random words with some skipped lower halves and flushes
      addr = 32'h1000;
      for (int i = 0; i < N_RANDOM; i++) begin
         r = lcg_next();
         w = lcg_next();
         if (r[4:0] == 5'd0)
            tbl.push_back(make_row(OP_FLUSH, '0, '0, '0, '0, '0));
         if (r[7:5] == 3'd0)
            tbl.push_back(make_row(OP_FETCH, addr + 32'd2, {16'h0, w[31:16]}, 2'b10,
                                   {1'b0, r[8] & r[9]}, {1'b0, r[10] & r[11] & r[12]}));
         else
            tbl.push_back(make_row(OP_FETCH, addr, w, 2'b11, r[14:13] & r[16:15],
                                   r[19:18] & r[21:20] & r[23:22]));
         addr = addr + 32'd4;
      end
      // two 2-byte parcels close any 4-byte instruction left open
      tbl.push_back(make_row(OP_FETCH, addr, 32'h0001_0001, 2'b11, 2'b00, 2'b00));
      tbl.push_back(make_row(OP_DRAIN, '0, '0, '0, '0, '0));
   endtask

`endif

// File: dv/tb_aligner.sv
//********************
// fetch aligner testbench with table stimulus and a halfword reference model
//********************
`timescale 1ns/1ps

module tb_aligner import fetch_pkg::*, instr_pkg::*; ();

   localparam int CLK_PERIOD = 20;
   localparam int ROW_CYCLES = 40;   // watchdog budget per table row

   logic        clk;
   logic        arst_n;
   logic        flush;
   logic        async_error;
   logic        fetch_valid;
   half_flags_t fetch_half_val;
   fetch_word_t fetch_data;
   pc_t         fetch_pc;
   half_flags_t fetch_icaf;
   half_flags_t fetch_dbecc;
   logic        decode_take;
   logic        i0_valid;
   instr_u      i0_instr;
   parcel_t     i0_cinst;
   pc_t         i0_pc;
   logic        i0_pc4;
   logic        i0_icaf;
   logic        i0_icaf_second;
   logic        i0_dbecc;
   logic        consume1;
   logic        consume2;
   logic        instr_aligned;

   // one halfword of the reference stream
   typedef struct packed {
      parcel_t par;
      pc_t     pc;
      logic    icaf;
      logic    dbecc;
      logic    last;   // last halfword of its fetch word
   } half_t;

   half_t mq[$];
   int    occupancy;
   int    takes_seen;
   logic  stall_exp;
   logic  table_ready = 1'b0;
   string test_name;

   `include "tb_vectors.svh"

   ifu_aligner_top uut (
      .clk            (clk),
      .arst_n         (arst_n),
      .flush          (flush),
      .async_error    (async_error),
      .fetch_valid    (fetch_valid),
      .fetch_half_val (fetch_half_val),
      .fetch_data     (fetch_data),
      .fetch_pc       (fetch_pc),
      .fetch_icaf     (fetch_icaf),
      .fetch_dbecc    (fetch_dbecc),
      .decode_take    (decode_take),
      .i0_valid       (i0_valid),
      .i0_instr       (i0_instr),
      .i0_cinst       (i0_cinst),
      .i0_pc          (i0_pc),
      .i0_pc4         (i0_pc4),
      .i0_icaf        (i0_icaf),
      .i0_icaf_second (i0_icaf_second),
      .i0_dbecc       (i0_dbecc),
      .consume1       (consume1),
      .consume2       (consume2),
      .instr_aligned  (instr_aligned)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   //********************
   // checks
   //********************
   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("STATUS: FAIL");
      $fatal(1, "aligner testbench stopped");
   endtask

   task automatic compare_instr(input string name, input instr_u exp, input instr_u act);
      if (act !== exp)
         stop_on_error($sformatf("Fail %s %s: expected %h, actual %h", test_name, name, exp, act));
   endtask

   task automatic compare_parcel(input string name, input parcel_t exp, input parcel_t act);
      if (act !== exp)
         stop_on_error($sformatf("Fail %s %s: expected %h, actual %h", test_name, name, exp, act));
   endtask

   task automatic compare_pc(input string name, input pc_t exp, input pc_t act);
      if (act !== exp)
         stop_on_error($sformatf("Fail %s %s: expected %h, actual %h", test_name, name, exp, act));
   endtask

   task automatic compare_flag(input string name, input logic exp, input logic act);
      if (act !== exp)
         stop_on_error($sformatf("Fail %s %s: expected %b, actual %b", test_name, name, exp, act));
   endtask

   //********************
   // reference model
   //********************
   // a full word gives two halfwords and a skipped lower half only data[0]
   task automatic push_fetch();
      half_t h;
      h.par   = fetch_data[0];
      h.pc    = fetch_pc;
      h.icaf  = fetch_icaf[0];
      h.dbecc = fetch_dbecc[0];
      h.last  = (fetch_half_val != 2'b11);
      mq.push_back(h);
      if (fetch_half_val == 2'b11) begin
         h.par   = fetch_data[1];
         h.pc    = fetch_pc + pc_t'(1);
         h.icaf  = fetch_icaf[1];
         h.dbecc = fetch_dbecc[1];
         h.last  = 1'b1;
         mq.push_back(h);
      end
      occupancy++;
   endtask

   task automatic check_cycle();
      half_t       h0;
      half_t       h1;
      instr_u      exp_i;
      logic        is4;
      logic        exp_valid;
      logic        exp_take;
      logic [63:0] d;
      int          ncons;
      h0    = '0;
      h1    = '0;
      is4   = 1'b0;
      ncons = 0;
      if (mq.size() > 0) begin
         h0  = mq[0];
         is4 = (h0.par[1:0] == OPC_LEN_32);
      end
      if (is4 && mq.size() > 1)
         h1 = mq[1];   // stays zero for a 2-byte instruction
      exp_valid = (mq.size() > 0) && (!is4 || mq.size() > 1);
      compare_flag("i0_valid", exp_valid, i0_valid);
      if (exp_valid) begin
         exp_i.half.lo = h0.par;
         exp_i.half.hi = h1.par;
         compare_instr("i0_instr", exp_i, i0_instr);
         compare_parcel("i0_cinst", h0.par, i0_cinst);
         compare_pc("i0_pc", h0.pc, i0_pc);
         compare_flag("i0_pc4", is4, i0_pc4);
         compare_flag("i0_icaf", h0.icaf | h1.icaf, i0_icaf);
         compare_flag("i0_dbecc", h0.dbecc | h1.dbecc, i0_dbecc);
         compare_flag("i0_icaf_second",
                      is4 & ~(h0.icaf | h0.dbecc) & (h1.icaf | h1.dbecc), i0_icaf_second);
      end
      exp_take = decode_take & exp_valid & ~stall_exp;
      compare_flag("instr_aligned", exp_take, instr_aligned);
      if (exp_take) begin
         if (takes_seen < dir_exp.size()) begin
            d     = dir_exp[takes_seen];
            exp_i = d[63:32];
            compare_instr("directed instr", exp_i, i0_instr);
            compare_pc("directed pc", d[31:1], i0_pc);
         end
         takes_seen++;
         ncons = int'(h0.last) + int'(h1.last);
         void'(mq.pop_front());
         if (is4)
            void'(mq.pop_front());
      end
      if (flush)
         ncons = 0;   // nothing reported in the flush cycle
      compare_flag("consume1", ncons == 1, consume1);
      compare_flag("consume2", ncons == 2, consume2);
      occupancy -= ncons;
      if (flush) begin
         mq.delete();
         occupancy = 0;
         stall_exp = 1'b0;
      end else begin
         if (fetch_valid)
            push_fetch();
         if (async_error)
            stall_exp = 1'b1;
      end
      if (occupancy < 0 || occupancy > QUEUE_DEPTH)
         stop_on_error($sformatf("buffer count %0d left the range 0 to 3 in %s",
                                 occupancy, test_name));
   endtask

   // drive on the rising edge and check on the falling edge
   task automatic run_cycle(input logic fv, input fetch_row_t cur, input logic fl,
                            input logic er);
      logic [31:0] r;
      r = lcg_next();
      @(posedge clk);
      fetch_valid    <= fv;
      fetch_half_val <= cur.hval;
      fetch_data     <= cur.data;
      fetch_pc       <= cur.addr[31:1];
      fetch_icaf     <= cur.icaf;
      fetch_dbecc    <= cur.dbecc;
      flush          <= fl;
      async_error    <= er;
      decode_take    <= fl | (r[31:30] != 2'b00);   // random stalls except in a flush cycle
      @(negedge clk);
      check_cycle();
   endtask

   //********************
   // main sequence and watchdog
   //********************
   initial begin : main
      fetch_row_t cur;
      fetch_row_t idle;
      clk            = 1'b0;
      arst_n         = 1'b0;
      flush          = 1'b0;
      async_error    = 1'b0;
      fetch_valid    = 1'b0;
      fetch_half_val = '0;
      fetch_data     = '0;
      fetch_pc       = '0;
      fetch_icaf     = '0;
      fetch_dbecc    = '0;
      decode_take    = 1'b0;
      occupancy      = 0;
      takes_seen     = 0;
      stall_exp      = 1'b0;
      test_name      = "reset";
      idle           = '0;
      load_table();
      table_ready = 1'b1;
      repeat (3) @(posedge clk);
      arst_n <= 1'b1;
      for (int i = 0; i < tbl.size(); i++) begin
         cur       = tbl[i];
         test_name = $sformatf("row %0d", i);
         case (cur.op)
            OP_FETCH: begin
               while (occupancy >= QUEUE_DEPTH)
                  run_cycle(1'b0, idle, 1'b0, 1'b0);
               run_cycle(1'b1, cur, 1'b0, 1'b0);
            end
            OP_FLUSH: run_cycle(1'b0, idle, 1'b1, 1'b0);
            OP_ERROR: begin
               run_cycle(1'b0, idle, 1'b0, 1'b1);
               repeat (8) run_cycle(1'b0, idle, 1'b0, 1'b0);
            end
            OP_DRAIN: begin
               while (mq.size() != 0)
                  run_cycle(1'b0, idle, 1'b0, 1'b0);
            end
            default: stop_on_error("unknown operation in the stimulus table");
         endcase
      end
      @(posedge clk);
      if (occupancy == 0 && takes_seen > dir_exp.size()) begin
         $display("STATUS: PASS");
         $finish;
      end else begin
         stop_on_error($sformatf("stream ended with %0d buffers unconsumed after %0d takes",
                                 occupancy, takes_seen));
      end
   end

   initial begin : watchdog
      int limit;
      wait (table_ready);
      limit = (ROW_CYCLES * tbl.size() + 20) * CLK_PERIOD;
      #(limit);
      stop_on_error($sformatf("timeout after %0d ns, the aligner stopped making progress",
                              limit));
   end

endmodule

// File: hw/fetch_pkg.sv
//********************
// fetch side types for pc, fetch word and halfword flags
// queue pointer and queue sizing constants
//********************
package fetch_pkg;

   localparam int HALF_W           = 16;
   localparam int PARCELS_PER_WORD = 2;
   localparam int QUEUE_DEPTH      = 3;   // fixed by the f0/f1/f2 slot scheme

   // halfword aligned pc, bit 0 is never stored
   typedef logic [31:1] pc_t;

   // fetch word as two halfwords, index 0 is the lower one
   typedef logic [PARCELS_PER_WORD-1:0][HALF_W-1:0] fetch_word_t;

   // one flag per halfword, used for valid, access fault and double ecc
   typedef logic [PARCELS_PER_WORD-1:0] half_flags_t;

   typedef logic [1:0] qptr_t;   // 0 to 2 only

endpackage

// File: hw/fetch_queue.sv
//********************
// three-entry fetch buffer with pointers, offsets and f0/f1 read-out
//********************
`timescale 1ns/1ps

module fetch_queue import fetch_pkg::*; (
   input  logic        clk,
   input  logic        arst_n,
   input  logic        flush,
   input  logic        fetch_valid,
   input  fetch_word_t fetch_data,
   input  pc_t         fetch_pc,
   input  half_flags_t fetch_icaf,
   input  half_flags_t fetch_dbecc,
   input  logic        consume1,
   input  logic        consume2,
   input  logic        f0_shift_2b,
   input  logic        f1_shift_2b,
   output fetch_word_t f0_word,
   output fetch_word_t f1_word,
   output pc_t         f0_pc,
   output pc_t         f1_pc,
   output half_flags_t f0_icaf,
   output half_flags_t f0_dbecc,
   output half_flags_t f1_icaf,
   output half_flags_t f1_dbecc
);

   qptr_t                  wrptr, wrptr_in;
   qptr_t                  rdptr, rdptr_in;
   qptr_t                  rd1ptr;
   logic [QUEUE_DEPTH-1:0] qwen;
   logic [QUEUE_DEPTH-1:0] qoff, qoff_in;
   logic [1:0]             q_cnt, q_cnt_in;
   logic                   off0, off1;

   fetch_word_t q_data  [QUEUE_DEPTH];
   pc_t         q_pc    [QUEUE_DEPTH];
   half_flags_t q_icaf  [QUEUE_DEPTH];
   half_flags_t q_dbecc [QUEUE_DEPTH];

   function automatic qptr_t ptr_inc(qptr_t p);
      return (p == qptr_t'(QUEUE_DEPTH - 1)) ? '0 : p + 2'd1;
   endfunction

   // drop the lower halfword once it has been taken
   function automatic fetch_word_t word_window(fetch_word_t w, logic off);
      fetch_word_t r;
      r = w;
      if (off) begin
         r[0] = w[1];
         r[1] = '0;
      end
      return r;
   endfunction

   function automatic half_flags_t flag_window(half_flags_t f, logic off);
      return off ? {1'b0, f[1]} : f;
   endfunction

   //********************
   // pointer and offset control
   //********************
   assign rd1ptr = ptr_inc(rdptr);

   always_comb begin
      for (int i = 0; i < QUEUE_DEPTH; i++) begin
         qwen[i] = fetch_valid & (wrptr == qptr_t'(i));
      end
   end

   assign wrptr_in = flush       ? '0 :
                     fetch_valid ? ptr_inc(wrptr) : wrptr;

   always_comb begin
      rdptr_in = rdptr;
      if (flush)
         rdptr_in = '0;
      else if (consume2)
         rdptr_in = ptr_inc(rd1ptr);
      else if (consume1)
         rdptr_in = rd1ptr;
   end

   // offset sticks until the entry is rewritten
   always_comb begin
      for (int i = 0; i < QUEUE_DEPTH; i++) begin
         if (flush || qwen[i])
            qoff_in[i] = 1'b0;
         else if (rdptr == qptr_t'(i))
            qoff_in[i] = qoff[i] | f0_shift_2b;
         else if (rd1ptr == qptr_t'(i))
            qoff_in[i] = qoff[i] | f1_shift_2b;
         else
            qoff_in[i] = qoff[i];
      end
   end

   // occupied entries, wraps mod 4 and stays within 0..3
   always_comb begin
      q_cnt_in = q_cnt + 2'(fetch_valid);
      if (consume2)
         q_cnt_in = q_cnt_in - 2'd2;
      else if (consume1)
         q_cnt_in = q_cnt_in - 2'd1;
      if (flush)
         q_cnt_in = '0;
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wrptr <= '0;
         rdptr <= '0;
         qoff  <= '0;
         q_cnt <= '0;
      end else begin
         wrptr <= wrptr_in;
         rdptr <= rdptr_in;
         qoff  <= qoff_in;
         q_cnt <= q_cnt_in;
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < QUEUE_DEPTH; i++) begin
         if (qwen[i]) begin
            q_data[i]  <= fetch_data;
            q_pc[i]    <= fetch_pc;
            q_icaf[i]  <= fetch_icaf;
            q_dbecc[i] <= fetch_dbecc;
         end
      end
   end

   //********************
   // windowed read-out of the two oldest entries
   //********************
   assign off0 = qoff[rdptr];
   assign off1 = qoff[rd1ptr];

   assign f0_word  = word_window(q_data[rdptr], off0);
   assign f0_pc    = q_pc[rdptr] + pc_t'(off0);   // skip the taken halfword
   assign f0_icaf  = flag_window(q_icaf[rdptr], off0);
   assign f0_dbecc = flag_window(q_dbecc[rdptr], off0);

   assign f1_word  = word_window(q_data[rd1ptr], off1);
   assign f1_pc    = q_pc[rd1ptr] + pc_t'(off1);
   assign f1_icaf  = flag_window(q_icaf[rd1ptr], off1);
   assign f1_dbecc = flag_window(q_dbecc[rd1ptr], off1);

   a_ptr_range: assert property (@(posedge clk) disable iff (!arst_n)
      (wrptr < QUEUE_DEPTH) && (rdptr < QUEUE_DEPTH))
      else $error("fetch queue pointer out of range");

   // a full queue only takes a word when the oldest one leaves this cycle
   a_no_overwrite: assert property (@(posedge clk) disable iff (!arst_n)
      fetch_valid && !flush |-> (q_cnt < QUEUE_DEPTH) || consume1 || consume2)
      else $error("fetch written over an unconsumed buffer");

endmodule

// File: hw/fetch_slot_ctl.sv
//********************
// f0/f1/f2 slot valids, shift decisions, error stall and consume reports
//********************
`timescale 1ns/1ps

module fetch_slot_ctl import fetch_pkg::*; (
   input  logic        clk,
   input  logic        arst_n,
   input  logic        flush,
   input  logic        async_error,
   input  logic        fetch_valid,
   input  half_flags_t fetch_half_val,
   input  logic        decode_take,
   input  logic        first_4b,
   output half_flags_t f0_val,
   output half_flags_t f1_val,
   output logic        f0_shift_2b,
   output logic        f1_shift_2b,
   output logic        consume1,
   output logic        consume2,
   output logic        take
);

   half_flags_t f2_val;
   half_flags_t f0_val_in, f1_val_in, f2_val_in;
   half_flags_t sf0_val, sf1_val;
   half_flags_t fetch_val;
   logic        error_stall, error_stall_in;
   logic        inst_avail;
   logic        shift_2b, shift_4b;
   logic        sf0_valid, sf1_valid, f2_valid;
   logic        shift_f1_f0, shift_f2_f0, shift_f2_f1;
   logic        fetch_to_f0, fetch_to_f1, fetch_to_f2;
   logic        consume_f0, consume_f1;

   // a single halfword fetch arrives right-justified
   assign fetch_val = {&fetch_half_val, |fetch_half_val};

   assign error_stall_in = (error_stall | async_error) & ~flush;

   // same length rule as the builder, a 4-byte straddle needs f1
   assign inst_avail = f0_val[1] | (f0_val[0] & (~first_4b | f1_val[0]));
   assign take       = decode_take & inst_avail & ~error_stall;

   assign shift_2b = take & ~first_4b;
   assign shift_4b = take &  first_4b;

   assign f0_shift_2b = (shift_2b & f0_val[0]) |
                        (shift_4b & f0_val[0] & ~f0_val[1]);
   assign f1_shift_2b = shift_4b & f0_val[0] & ~f0_val[1];   // straddle eats f1 low half

   // valids after this cycle's take
   assign sf0_val = shift_2b ? {1'b0, f0_val[1]} :
                    shift_4b ? 2'b00 : f0_val;
   assign sf1_val = f1_shift_2b ? {1'b0, f1_val[1]} : f1_val;

   //********************
   // compaction, state is {sf0, sf1, f2}
   //********************
   // 000 fetch to f0        100 fetch to f1
   // 010 f1 to f0, fetch to f1
   // 001 f2 to f0, fetch to f1
   // 110 fetch to f2        111 hold
   // 011 f1 to f0, f2 to f1, fetch to f2
   assign sf0_valid = sf0_val[0];
   assign sf1_valid = sf1_val[0];
   assign f2_valid  = f2_val[0];

   assign shift_f1_f0 = ~sf0_valid &  sf1_valid;
   assign shift_f2_f0 = ~sf0_valid & ~sf1_valid & f2_valid;
   assign shift_f2_f1 = ~sf0_valid &  sf1_valid & f2_valid;

   assign fetch_to_f0 = fetch_valid & ~sf0_valid & ~sf1_valid & ~f2_valid;
   assign fetch_to_f1 = fetch_valid & ((~sf0_valid & (sf1_valid ^ f2_valid)) |
                                       ( sf0_valid & ~sf1_valid & ~f2_valid));
   assign fetch_to_f2 = fetch_valid & sf1_valid & (sf0_valid ^ f2_valid);

   always_comb begin
      f2_val_in = f2_val;
      if (fetch_to_f2)
         f2_val_in = fetch_val;
      else if (shift_f2_f1 || shift_f2_f0)
         f2_val_in = '0;

      f1_val_in = sf1_val;
      if (fetch_to_f1)
         f1_val_in = fetch_val;
      else if (shift_f2_f1)
         f1_val_in = f2_val;
      else if (shift_f1_f0)
         f1_val_in = '0;

      f0_val_in = sf0_val;
      if (fetch_to_f0)
         f0_val_in = fetch_val;
      else if (shift_f2_f0)
         f0_val_in = f2_val;
      else if (shift_f1_f0)
         f0_val_in = sf1_val;

      if (flush) begin
         f0_val_in = '0;
         f1_val_in = '0;
         f2_val_in = '0;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         f0_val      <= '0;
         f1_val      <= '0;
         f2_val      <= '0;
         error_stall <= 1'b0;
      end else begin
         f0_val      <= f0_val_in;
         f1_val      <= f1_val_in;
         f2_val      <= f2_val_in;
         error_stall <= error_stall_in;
      end
   end

   // buffers emptied by this take
   assign consume_f0 = f0_val[0] & ~sf0_val[0];
   assign consume_f1 = f1_val[0] & ~sf1_val[0];

   assign consume1 = consume_f0 & ~consume_f1 & ~flush;
   assign consume2 = consume_f0 &  consume_f1 & ~flush;

   a_no_hole: assert property (@(posedge clk) disable iff (!arst_n)
      {sf0_valid, sf1_valid, f2_valid} != 3'b101)
      else $error("slot f1 empty between valid f0 and f2");

endmodule

// File: hw/ifu_aligner_top.sv
//********************
// fetch aligner top, queue plus slot control plus builder
//********************
`timescale 1ns/1ps

module ifu_aligner_top import fetch_pkg::*, instr_pkg::*; (
   input  logic        clk,
   input  logic        arst_n,
   input  logic        flush,
   input  logic        async_error,
   input  logic        fetch_valid,
   input  half_flags_t fetch_half_val,
   input  fetch_word_t fetch_data,
   input  pc_t         fetch_pc,
   input  half_flags_t fetch_icaf,
   input  half_flags_t fetch_dbecc,
   input  logic        decode_take,
   output logic        i0_valid,
   output instr_u      i0_instr,
   output parcel_t     i0_cinst,
   output pc_t         i0_pc,
   output logic        i0_pc4,
   output logic        i0_icaf,
   output logic        i0_icaf_second,
   output logic        i0_dbecc,
   output logic        consume1,
   output logic        consume2,
   output logic        instr_aligned
);

   fetch_word_t f0_word, f1_word;
   pc_t         f0_pc;
   half_flags_t f0_icaf, f0_dbecc, f1_icaf, f1_dbecc;
   half_flags_t f0_val, f1_val;
   logic        f0_shift_2b, f1_shift_2b;
   logic        first_4b;
   logic        take;

   fetch_queue u_queue (
      .clk         (clk),
      .arst_n      (arst_n),
      .flush       (flush),
      .fetch_valid (fetch_valid),
      .fetch_data  (fetch_data),
      .fetch_pc    (fetch_pc),
      .fetch_icaf  (fetch_icaf),
      .fetch_dbecc (fetch_dbecc),
      .consume1    (consume1),
      .consume2    (consume2),
      .f0_shift_2b (f0_shift_2b),
      .f1_shift_2b (f1_shift_2b),
      .f0_word     (f0_word),
      .f1_word     (f1_word),
      .f0_pc       (f0_pc),
      .f1_pc       (),               // builder only needs the head pc
      .f0_icaf     (f0_icaf),
      .f0_dbecc    (f0_dbecc),
      .f1_icaf     (f1_icaf),
      .f1_dbecc    (f1_dbecc)
   );

   fetch_slot_ctl u_slot (
      .clk            (clk),
      .arst_n         (arst_n),
      .flush          (flush),
      .async_error    (async_error),
      .fetch_valid    (fetch_valid),
      .fetch_half_val (fetch_half_val),
      .decode_take    (decode_take),
      .first_4b       (first_4b),
      .f0_val         (f0_val),
      .f1_val         (f1_val),
      .f0_shift_2b    (f0_shift_2b),
      .f1_shift_2b    (f1_shift_2b),
      .consume1       (consume1),
      .consume2       (consume2),
      .take           (take)
   );

   instr_align u_align (
      .f0_val         (f0_val),
      .f1_val         (f1_val),
      .f0_word        (f0_word),
      .f1_word        (f1_word),
      .f0_pc          (f0_pc),
      .f0_icaf        (f0_icaf),
      .f0_dbecc       (f0_dbecc),
      .f1_icaf        (f1_icaf),
      .f1_dbecc       (f1_dbecc),
      .take           (take),
      .first_4b       (first_4b),
      .i0_valid       (i0_valid),
      .i0_instr       (i0_instr),
      .i0_cinst       (i0_cinst),
      .i0_pc          (i0_pc),
      .i0_pc4         (i0_pc4),
      .i0_icaf        (i0_icaf),
      .i0_icaf_second (i0_icaf_second),
      .i0_dbecc       (i0_dbecc),
      .instr_aligned  (instr_aligned)
   );

endmodule

// File: hw/instr_align.sv
//********************
// aligned instruction, pc and fault flags for decode
//********************
`timescale 1ns/1ps

module instr_align import fetch_pkg::*, instr_pkg::*; (
   input  half_flags_t f0_val,
   input  half_flags_t f1_val,
   input  fetch_word_t f0_word,
   input  fetch_word_t f1_word,
   input  pc_t         f0_pc,
   input  half_flags_t f0_icaf,
   input  half_flags_t f0_dbecc,
   input  half_flags_t f1_icaf,
   input  half_flags_t f1_dbecc,
   input  logic        take,
   output logic        first_4b,
   output logic        i0_valid,
   output instr_u      i0_instr,
   output parcel_t     i0_cinst,
   output pc_t         i0_pc,
   output logic        i0_pc4,
   output logic        i0_icaf,
   output logic        i0_icaf_second,
   output logic        i0_dbecc,
   output logic        instr_aligned
);

   instr_u      align_data;
   half_flags_t align_val;
   half_flags_t align_icaf;
   half_flags_t align_dbecc;
   half_flags_t fault_any;
   logic        f0_full, f0_half;

   assign f0_full = f0_val[1];
   assign f0_half = ~f0_val[1] & f0_val[0];

   //********************
   // pick the two parcels at the head
   //********************
   always_comb begin
      align_data  = '0;
      align_val   = '0;
      align_icaf  = '0;
      align_dbecc = '0;
      if (f0_full) begin
         align_data.word = f0_word;
         align_val       = 2'b11;
         align_icaf      = f0_icaf;
         align_dbecc     = f0_dbecc;
      end else if (f0_half) begin
         // upper parcel comes from the next buffer
         align_data.half.lo = f0_word[0];
         align_data.half.hi = f1_word[0];
         align_val          = {f1_val[0], 1'b1};
         align_icaf         = {f1_icaf[0], f0_icaf[0]};
         align_dbecc        = {f1_dbecc[0], f0_dbecc[0]};
      end
   end

   //********************
   // length, valid and instruction word
   //********************
   assign first_4b = (align_data.half.lo[1:0] == OPC_LEN_32);

   assign i0_valid = first_4b ? align_val[1] : align_val[0];

   always_comb begin
      i0_instr = '0;
      if (first_4b && align_val[1])
         i0_instr = align_data;
      else if (!first_4b && align_val[0])
         i0_instr.half.lo = align_data.half.lo;   // compressed, upper parcel zero
   end

   assign i0_cinst = align_data.half.lo;
   assign i0_pc    = f0_pc;
   assign i0_pc4   = first_4b;

   //********************
   // faults over the covered parcels
   //********************
   assign i0_icaf  = first_4b ? |align_icaf  : align_icaf[0];
   assign i0_dbecc = first_4b ? |align_dbecc : align_dbecc[0];

   // either error kind marks a parcel bad
   assign fault_any = align_icaf | align_dbecc;

   // clean first half, bad second half of a 4-byte instruction
   assign i0_icaf_second = first_4b & ~fault_any[0] & fault_any[1];

   assign instr_aligned = take;

endmodule

// File: hw/instr_pkg.sv
//********************
// instruction side parcel constants and aligned instruction union
//********************
package instr_pkg;

   localparam int PARCEL_W = 16;
   localparam int INSTR_W  = 2 * PARCEL_W;

   // low opcode bits of a 4-byte instruction
   localparam logic [1:0] OPC_LEN_32 = 2'b11;

   typedef logic [PARCEL_W-1:0] parcel_t;

   // full word for a 4-byte instruction
   // lo parcel alone for a compressed one
   typedef union packed {
      logic [INSTR_W-1:0] word;
      struct packed {
         parcel_t hi;
         parcel_t lo;
      } half;
   } instr_u;

endpackage

// File: sim.f
+incdir+dv
hw/fetch_pkg.sv
hw/instr_pkg.sv
hw/fetch_queue.sv
hw/fetch_slot_ctl.sv
hw/instr_align.sv
hw/ifu_aligner_top.sv
dv/tb_aligner.sv
